/* list.f */
rtl/dl_map_pkg.sv
rtl/dl_bus_pkg.sv
rtl/dl_region.sv
rtl/dl_lane.sv
rtl/dl_swizzle.sv
rtl/rom_dwnld.sv
tests/tb_rom_dwnld.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the ROM download testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
PASS_LINE="Simulation completed successfully"

verilator --binary -j 0 --timescale 1ns/1ps --top-module tb_rom_dwnld \
    -f list.f -Mdir "$BUILD_DIR" -o tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/tb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "$PASS_LINE" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

/* tests/tb_rom_dwnld.sv */
/* Testbench for the ROM download path. It drives loader bytes and compares the SDRAM and
   PROM writes with a reference model, checking the three-cycle latency of every write */
`timescale 1ns/1ps
`default_nettype none

module tb_rom_dwnld
    import dl_map_pkg::*, dl_bus_pkg::*;
();

    localparam int CLK_PERIOD   = 4;
    localparam int RST_CYCLES   = 3;
    localparam int IDLE_CYCLES  = 5;
    localparam int LATENCY      = 3;
    localparam int DIR_BYTES    = 28;
    localparam int DIR_CYCLES   = DIR_BYTES * (LATENCY + 1);  // Each byte then an idle gap
    localparam int OFF_CYCLES   = 4;
    localparam int SWEEP_CYCLES = 96;
    localparam int N_BURST      = 128;
    localparam int N_RANDOM     = 256;
    localparam int DRAIN_CYCLES = 8;
    localparam int TOTAL_CYCLES = RST_CYCLES + IDLE_CYCLES + DIR_CYCLES + OFF_CYCLES
                                + SWEEP_CYCLES + N_BURST + N_RANDOM + DRAIN_CYCLES;
    localparam logic [31:0] ADDR_SPAN = {7'd0, PROM_START + PROM_LEN} + 32'h400;

    typedef enum logic [1:0] {EXP_NONE, EXP_SDRAM, EXP_PROM} exp_kind_e;

    typedef struct packed {
        logic [31:0]  due;  // Cycle in which the strobe is expected
        dl_sdram_wr_t wr;
    } sdram_exp_t;

    typedef struct packed {
        logic [31:0] due;
        dl_prom_wr_t wr;
    } prom_exp_t;

    logic         clk = 1'b0;
    logic         rst;
    logic         downloading;
    logic         ioctl_wr;
    logic [24:0]  ioctl_addr;
    logic [ 7:0]  ioctl_dout;
    dl_sdram_wr_t prog;
    logic         prog_we;
    dl_prom_wr_t  prom;
    logic         prom_we;

    logic [31:0]  cycle = 32'd0;
    logic [31:0]  lcg_state = 32'hddfef293;
    sdram_exp_t   sdram_q[$];
    prom_exp_t    prom_q[$];
    logic [24:0]  dir_addr [DIR_BYTES];

    rom_dwnld u_rom_dwnld (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .downloading ( downloading ),
        .ioctl_wr    ( ioctl_wr    ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .prog        ( prog        ),
        .prog_we     ( prog_we     ),
        .prom        ( prom        ),
        .prom_we     ( prom_we     )
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;  // Counts rising edges
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Expected write for one accepted loader byte
    function automatic exp_kind_e expect_write(input logic [24:0] addr, input logic [7:0] data,
                                               output dl_sdram_wr_t sd, output dl_prom_wr_t pr);
        logic [21:0] w;
        logic [24:0] off;
        exp_kind_e   kind;
        sd   = '0;
        pr   = '0;
        w    = {1'b0, addr[21:1]};
        off  = addr - PROM_START;
        kind = EXP_SDRAM;
        if (addr >= PROM_START + PROM_LEN) begin
            kind = EXP_NONE;
        end else if (addr >= PROM_START) begin
            kind    = EXP_PROM;
            pr.addr = off[10:0];
            pr.data = data;
        end else begin
            if (addr >= {3'd0, SCR_START} && addr < {3'd0, OBJ_START}) begin
                w[3:0] = {w[2:0], ~w[3]};  // Scroll tile row order
            end else if (addr >= {3'd0, OBJ_START} && addr < {3'd0, PCM_START}) begin
                w[4:0] = {w[2:0], ~w[4], ~w[3]};
            end
            sd.addr = w;
            sd.mask = addr[0] ? 2'b10 : 2'b01;  // Swapped lanes
            sd.data = data;
        end
        return kind;
    endfunction

    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string msg);
        $display("error at %0t: %s", $time, msg);
        stop_run();
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        stop_run();
    endtask

    task automatic check_sdram_wr(input dl_sdram_wr_t got, input dl_sdram_wr_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf("SDRAM write addr %h mask %b data %h, expected %h %b %h",
                                      got.addr, got.mask, got.data,
                                      exp.addr, exp.mask, exp.data));
        end
    endtask

    task automatic check_prom_wr(input dl_prom_wr_t got, input dl_prom_wr_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf("PROM write addr %h data %h, expected %h %h",
                                      got.addr, got.data, exp.addr, exp.data));
        end
    endtask

    // Called 1 ns after a rising edge, returns 1 ns after the next one
    task automatic drive_byte(input logic dl, input logic wr, input logic [24:0] addr,
                              input logic [7:0] data);
        dl_sdram_wr_t sd;
        dl_prom_wr_t  pr;
        exp_kind_e    kind;
        sdram_exp_t   se;
        prom_exp_t    pe;
        downloading = dl;
        ioctl_wr    = wr;
        ioctl_addr  = addr;
        ioctl_dout  = data;
        if (dl && wr) begin
            kind = expect_write(addr, data, sd, pr);
            if (kind == EXP_SDRAM) begin
                se.due = cycle + LATENCY;
                se.wr  = sd;
                sdram_q.push_back(se);
            end else if (kind == EXP_PROM) begin
                pe.due = cycle + LATENCY;
                pe.wr  = pr;
                prom_q.push_back(pe);
            end
        end
        @(posedge clk);
        #1;
    endtask

    // Outputs are sampled mid-cycle
    always @(negedge clk) begin
        sdram_exp_t se;
        prom_exp_t  pe;
        if (rst === 1'b0) begin
            if (prog_we === 1'b1 && prom_we === 1'b1) begin
                report_failure("SDRAM and PROM write strobes were high in the same cycle");
            end else if (prog_we === 1'b1) begin
                if (sdram_q.size() == 0) begin
                    report_failure("an SDRAM write arrived when none was expected");
                end else begin
                    se = sdram_q.pop_front();
                    if (se.due != cycle) begin
                        report_mismatch($sformatf("SDRAM write in cycle %0d, expected in %0d",
                                                  cycle, se.due));
                    end
                    check_sdram_wr(prog, se.wr);
                end
            end else if (prom_we === 1'b1) begin
                if (prom_q.size() == 0) begin
                    report_failure("a PROM write arrived when none was expected");
                end else begin
                    pe = prom_q.pop_front();
                    if (pe.due != cycle) begin
                        report_mismatch($sformatf("PROM write in cycle %0d, expected in %0d",
                                                  cycle, pe.due));
                    end
                    check_prom_wr(prom, pe.wr);
                end
            end
            if (sdram_q.size() > 0 && sdram_q[0].due < cycle) begin
                report_failure("an expected SDRAM write never arrived");
            end
            if (prom_q.size() > 0 && prom_q[0].due < cycle) begin
                report_failure("an expected PROM write never arrived");
            end
        end
    end

    initial begin
        #(CLK_PERIOD * (TOTAL_CYCLES + 50));
        report_failure("watchdog timeout, the test did not finish in time");
    end

    initial begin
        logic [24:0] addr;
        rst         = 1'b1;
        // Loader strobes held through reset must never come out
        downloading = 1'b1;
        ioctl_wr    = 1'b1;
        ioctl_addr  = 25'h00100;
        ioctl_dout  = 8'h96;
        // Both sides of every region boundary, then a few low-bit patterns
        dir_addr = '{25'h00000, 25'h00001, 25'h0FFFF,
                     25'h10000, 25'h10001, 25'h11FFF,
                     25'h12000, 25'h12001, 25'h12007, 25'h1200F, 25'h12010, 25'h19FFF,
                     25'h1A000, 25'h1A001, 25'h1A00F, 25'h1A01F, 25'h1A03F, 25'h21FFF,
                     25'h22000, 25'h22001, 25'h31FFF,
                     25'h32000, 25'h32001, 25'h322FF,
                     25'h32300, 25'h32301, 25'h3FFFF, 25'h1FFFFFF};
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (IDLE_CYCLES) drive_byte(1'b1, 1'b0, '0, '0);  // No strobe expected yet

        foreach (dir_addr[i]) begin
            lcg_state = lcg_next(lcg_state);
            drive_byte(1'b1, 1'b1, dir_addr[i], lcg_state[31:24]);
            repeat (LATENCY) drive_byte(1'b1, 1'b0, '0, '0);
        end

        // Loader strobes outside a download
        drive_byte(1'b0, 1'b1, 25'h00010, 8'h5a);
        drive_byte(1'b0, 1'b1, {3'd0, SCR_START}, 8'ha5);
        drive_byte(1'b0, 1'b1, PROM_START, 8'h3c);
        drive_byte(1'b0, 1'b1, 25'h22100, 8'hc3);

        for (int i = 0; i < SWEEP_CYCLES; i++) begin
            lcg_state = lcg_next(lcg_state);
            if (i < 32) begin
                addr = {3'd0, SCR_START} + 25'd32 + 25'(i);
            end else begin
                addr = {3'd0, OBJ_START} + 25'd32 + 25'(i);
            end
            drive_byte(1'b1, 1'b1, addr, lcg_state[31:24]);
        end

        for (int i = 0; i < N_BURST; i++) begin
            lcg_state = lcg_next(lcg_state);
            addr = 25'(lcg_state % ADDR_SPAN);
            drive_byte(1'b1, 1'b1, addr, lcg_state[31:24]);
        end

        // Random gaps and short pauses of the download
        for (int i = 0; i < N_RANDOM; i++) begin
            lcg_state = lcg_next(lcg_state);
            addr = 25'(lcg_state % ADDR_SPAN);
            drive_byte(lcg_state[29:27] != 3'd0, lcg_state[31] | lcg_state[30], addr,
                       lcg_state[23:16]);
        end

        repeat (DRAIN_CYCLES) drive_byte(1'b1, 1'b0, '0, '0);
        if (sdram_q.size() != 0 || prom_q.size() != 0) begin
            report_failure($sformatf("%0d SDRAM and %0d PROM writes were still outstanding",
                                     sdram_q.size(), prom_q.size()));
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* rtl/rom_dwnld.sv */
/* ROM download path from the host loader to SDRAM and colour PROM writes.
   Three registered stages, one byte accepted per cycle, output three cycles later */
`timescale 1ns/1ps
`default_nettype none

module rom_dwnld
    import dl_bus_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         downloading,
    input  logic         ioctl_wr,
    input  logic [24:0]  ioctl_addr,
    input  logic [ 7:0]  ioctl_dout,
    output dl_sdram_wr_t prog,
    output logic         prog_we,
    output dl_prom_wr_t  prom,
    output logic         prom_we
);

    dl_byte_t byte_q;
    logic     byte_vld;
    dl_word_t word_q;
    logic     word_vld;

    dl_region u_region (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .downloading ( downloading ),
        .ioctl_wr    ( ioctl_wr    ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .byte_q      ( byte_q      ),
        .byte_vld    ( byte_vld    )
    );

    dl_lane u_lane (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .byte_q   ( byte_q   ),
        .byte_vld ( byte_vld ),
        .word_q   ( word_q   ),
        .word_vld ( word_vld )
    );

    dl_swizzle u_swizzle (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .word_q   ( word_q   ),
        .word_vld ( word_vld ),
        .prog     ( prog     ),
        .prog_we  ( prog_we  ),
        .prom     ( prom     ),
        .prom_we  ( prom_we  )
    );

endmodule

`default_nettype wire

/* rtl/dl_swizzle.sv */
/* Download stage 3: reorders low address bits of graphics data and drives the write ports.
   Scroll and object words land so the video fetch reads whole 32-bit tile rows */
`timescale 1ns/1ps
`default_nettype none

module dl_swizzle
    import dl_map_pkg::*, dl_bus_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  dl_word_t     word_q,
    input  logic         word_vld,
    output dl_sdram_wr_t prog,
    output logic         prog_we,
    output dl_prom_wr_t  prom,
    output logic         prom_we
);

    logic [21:0] sw_addr;
    logic        is_prom;

    assign is_prom = (word_q.region == REG_PROM);

    always_comb begin
        sw_addr = word_q.addr;
        case (word_q.region)
            REG_SCR: begin
                sw_addr[3:0] = {word_q.addr[2:0], ~word_q.addr[3]};
            end
            REG_OBJ: begin
                sw_addr[4:0] = {word_q.addr[2:0], ~word_q.addr[4], ~word_q.addr[3]};
            end
            default: begin
                sw_addr = word_q.addr;  // Code, samples and PROM as they are
            end
        endcase
    end

    // Only one of the two strobes fires per word
    always_ff @(posedge clk) begin
        if (rst) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            prog_we <= word_vld && !is_prom;
            prom_we <= word_vld && is_prom;
        end
    end

    always_ff @(posedge clk) begin
        prog.addr <= sw_addr;
        prog.mask <= word_q.mask;
        prog.data <= word_q.data;
        prom.addr <= word_q.addr[PROM_AW-1:0];
        prom.data <= word_q.data;
    end

endmodule

`default_nettype wire

/* rtl/dl_lane.sv */
/* Download stage 2: turns the byte address into an SDRAM word address and lane mask.
   PROM bytes get their offset from the start of the PROM area instead */
`timescale 1ns/1ps
`default_nettype none

module dl_lane
    import dl_map_pkg::*, dl_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  dl_byte_t byte_q,
    input  logic     byte_vld,
    output dl_word_t word_q,
    output logic     word_vld
);

    logic [21:0] word_addr;
    logic [ 1:0] word_mask;
    logic [21:0] prom_off;

    assign prom_off = byte_q.addr - PROM_START[21:0];

    always_comb begin
        if (byte_q.region == REG_PROM) begin
            word_addr = prom_off;  // Only the low PROM_AW bits matter
            word_mask = 2'b11;     // No SDRAM lane
        end else begin
            word_addr = {1'b0, byte_q.addr[21:1]};
            // Byte swapped, even bytes go to the upper lane
            if (byte_q.addr[0]) begin
                word_mask = 2'b10;
            end else begin
                word_mask = 2'b01;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            word_vld <= 1'b0;
        end else begin
            word_vld <= byte_vld;
        end
    end

    always_ff @(posedge clk) begin
        word_q.region <= byte_q.region;
        word_q.addr   <= word_addr;
        word_q.mask   <= word_mask;
        word_q.data   <= byte_q.data;
    end

endmodule

`default_nettype wire

/* rtl/dl_region.sv */
/* Download stage 1: sorts every loader byte into its memory map region.
   Bytes outside the ROM set or written while not downloading never leave this stage */
`timescale 1ns/1ps
`default_nettype none

module dl_region
    import dl_map_pkg::*, dl_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        downloading,
    input  logic        ioctl_wr,
    input  logic [24:0] ioctl_addr,
    input  logic [ 7:0] ioctl_dout,
    output dl_byte_t    byte_q,
    output logic        byte_vld
);

    dl_region_e region;
    logic       accept;

    // Boundaries are checked in ascending order
    always_comb begin
        if (ioctl_addr < {3'd0, SND_START}) begin
            region = REG_MAIN;
        end else if (ioctl_addr < {3'd0, SCR_START}) begin
            region = REG_SND;
        end else if (ioctl_addr < {3'd0, OBJ_START}) begin
            region = REG_SCR;
        end else if (ioctl_addr < {3'd0, PCM_START}) begin
            region = REG_OBJ;
        end else if (ioctl_addr < PROM_START) begin
            region = REG_PCM;
        end else if (ioctl_addr < PROM_END) begin
            region = REG_PROM;
        end else begin
            region = REG_NONE;
        end
    end

    // Out of range bytes are dropped here so later stages never check range
    assign accept = ioctl_wr && downloading && (region != REG_NONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            byte_vld <= 1'b0;
        end else begin
            byte_vld <= accept;
        end
    end

    always_ff @(posedge clk) begin
        byte_q.region <= region;
        byte_q.addr   <= ioctl_addr[21:0];  // Whole map fits in 22 bits
        byte_q.data   <= ioctl_dout;
    end

endmodule

`default_nettype wire

/* rtl/dl_bus_pkg.sv */
/* Payloads passed between the download pipeline stages and out of the top level.
   Every payload travels next to a single-cycle valid strobe */
`default_nettype none

package dl_bus_pkg;

    import dl_map_pkg::*;

    localparam int PROM_AW = 11;  // PROM write address width

    // Stage 1 output, byte sorted into its region
    typedef struct packed {
        dl_region_e  region;
        logic [21:0] addr;   // Byte address
        logic [ 7:0] data;
    } dl_byte_t;

    // Stage 2 output
    typedef struct packed {
        dl_region_e  region;
        logic [21:0] addr;   // Word address, or PROM offset in the low bits
        logic [ 1:0] mask;   // Active low byte lanes
        logic [ 7:0] data;
    } dl_word_t;

    // SDRAM write
    typedef struct packed {
        logic [21:0] addr;
        logic [ 1:0] mask;
        logic [ 7:0] data;
    } dl_sdram_wr_t;

    // Colour PROM write
    typedef struct packed {
        logic [PROM_AW-1:0] addr;
        logic [        7:0] data;
    } dl_prom_wr_t;

endpackage

`default_nettype wire

/* rtl/dl_map_pkg.sv */
/* Memory map of the game ROM set as the host loader sends it.
   Region boundaries are byte addresses; each region ends where the next one starts */
`default_nettype none

package dl_map_pkg;

    // SDRAM regions, the main CPU ROM sits at address zero
    localparam logic [21:0] SND_START  = 22'h10000;  // Sound CPU ROM
    localparam logic [21:0] SCR_START  = 22'h12000;  // Scroll tiles
    localparam logic [21:0] OBJ_START  = 22'h1A000;  // Object graphics
    localparam logic [21:0] PCM_START  = 22'h22000;  // PCM samples

    // Colour PROMs go to their own write port, not to SDRAM
    localparam logic [24:0] PROM_START = 25'h32000;
    localparam logic [24:0] PROM_LEN   = 25'h300;
    localparam logic [24:0] PROM_END   = PROM_START + PROM_LEN;  // First byte past the PROMs

    // Destination of one downloaded byte
    typedef enum logic [2:0] {
        REG_MAIN,
        REG_SND,
        REG_SCR,
        REG_OBJ,
        REG_PCM,
        REG_PROM,
        REG_NONE   // Past the end of the ROM set
    } dl_region_e;

endpackage

`default_nettype wire
